/* include/eth_macros.svh */
`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// station address, first byte on the wire is the top byte
`define ETH_MAC_ADDR 48'h0200_5e10_2030

// start of frame delimiter
// arrives as nibble 5 then nibble d
`define ETH_SFD 8'hd5

// crc register contents after a frame with a correct fcs
// register seeded with all ones, reflected shift, no final inversion
`define ETH_CRC_RESIDUE 32'hdebb_20e3

// frame buffer geometry
`define ETH_BUF_AW 11
`define ETH_BUF_DEPTH (1 << `ETH_BUF_AW)

`endif

/* hw/eth_mii_pkg.sv */
package eth_mii_pkg;

   // one mii receive sample per RX_CLK
   typedef struct packed {
      logic       dv;
      logic       er;
      logic [3:0] data;
   } mii_rx_t;

   // receiver states
   // st_low_nibble and st_high_nibble walk the bytes after the sfd
   typedef enum logic [2:0] {
      st_idle,
      st_low_nibble,
      st_high_nibble,
      st_drop,
      st_hold
   } rx_state_e;

endpackage

/* hw/eth_buf_pkg.sv */
`include "eth_macros.svh"

package eth_buf_pkg;

   // one byte write into the frame buffer
   typedef struct packed {
      logic                   wr;
      logic [`ETH_BUF_AW-1:0] addr;
      logic [7:0]             data;
   } buf_wr_t;

   // frame status towards the host
   // frame_len counts stored bytes, fcs included
   typedef struct packed {
      logic                 frame_received;
      logic [`ETH_BUF_AW:0] frame_len;
   } rx_status_t;

endpackage

/* hw/eth_crc.sv */
`include "eth_macros.svh"

module eth_crc (
   input  logic       clk,
   input  logic       rst,
   input  logic       clear,
   input  logic       en,
   input  logic [3:0] nibble,
   output logic       good
);

   // reflected ieee 802.3 polynomial
   localparam logic [31:0] POLY = 32'hedb8_8320;

   logic [31:0] crc;

   // four bits, lsb of the nibble first
   function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [3:0] d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 4; i++) begin
         if (r[0] ^ d[i]) begin
            r = (r >> 1) ^ POLY;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         crc <= '1;
      end else if (en) begin
         crc <= crc_step(crc, nibble);
      end
   end

   // fcs itself went through the register, so a good frame leaves the residue
   assign good = (crc == `ETH_CRC_RESIDUE);

endmodule

/* hw/eth_rx.sv */
`include "eth_macros.svh"

module eth_rx (
   input  logic                    RX_CLK,
   input  logic                    rst,
   input  eth_mii_pkg::mii_rx_t    mii,
   input  logic                    receive,
   output eth_buf_pkg::buf_wr_t    buf_wr,
   output eth_buf_pkg::rx_status_t status
);
   import eth_mii_pkg::*;

   localparam logic [47:0] BCAST_ADDR = '1;

   rx_state_e              state;
   logic                   armed;
   logic [3:0]             prev_nib;
   logic [3:0]             low_nib;
   logic [7:0]             rx_byte;
   logic [47:0]            dest;
   logic [47:0]            dest_next;
   logic [`ETH_BUF_AW:0]   byte_cnt;
   logic                   sfd_seen;
   logic                   addr_miss;
   logic                   crc_clear;
   logic                   crc_en;
   logic                   crc_good;
   logic                   wr_q;
   logic [`ETH_BUF_AW-1:0] wr_addr_q;
   logic [7:0]             wr_data_q;
   logic                   frame_received_q;
   logic [`ETH_BUF_AW:0]   frame_len_q;

   assign rx_byte   = {mii.data, low_nib};
   assign dest_next = {dest[39:0], rx_byte};
   assign addr_miss = (dest_next != `ETH_MAC_ADDR) && (dest_next != BCAST_ADDR);

   // sfd only counts once the line has been quiet since the last frame
   assign sfd_seen = armed && mii.dv && !mii.er && ({mii.data, prev_nib} == `ETH_SFD);

   assign crc_clear = (state == st_idle);
   assign crc_en    = ((state == st_low_nibble) || (state == st_high_nibble)) &&
                      mii.dv && !mii.er;

   eth_crc i_crc (
      .clk    (RX_CLK),
      .rst    (rst),
      .clear  (crc_clear),
      .en     (crc_en),
      .nibble (mii.data),
      .good   (crc_good)
   );

   always_ff @(posedge RX_CLK) begin
      if (rst) begin
         state            <= st_idle;
         armed            <= 1'b0;
         byte_cnt         <= '0;
         wr_q             <= 1'b0;
         frame_received_q <= 1'b0;
      end else begin
         wr_q  <= 1'b0;
         armed <= !mii.dv || (armed && (state == st_idle));
         case (state)
            st_idle: begin
               byte_cnt <= '0;
               if (sfd_seen) begin
                  state <= st_low_nibble;
               end
            end
            st_low_nibble: begin
               if (mii.er) begin
                  state <= st_drop;
               end else if (!mii.dv) begin
                  // end of frame on a byte boundary
                  if (crc_good) begin
                     state            <= st_hold;
                     frame_received_q <= 1'b1;
                  end else begin
                     state <= st_idle;
                  end
               end else begin
                  state <= st_high_nibble;
               end
            end
            st_high_nibble: begin
               if (mii.er) begin
                  state <= st_drop;
               end else if (!mii.dv) begin
                  // odd nibble count
                  state <= st_idle;
               end else begin
                  wr_q     <= 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  if ((byte_cnt == 5) && addr_miss) begin
                     state <= st_drop;
                  end else begin
                     state <= st_low_nibble;
                  end
               end
            end
            st_drop: begin
               if (!mii.dv) begin
                  state <= st_idle;
               end
            end
            st_hold: begin
               if (receive) begin
                  state            <= st_idle;
                  frame_received_q <= 1'b0;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      prev_nib <= mii.dv ? mii.data : 4'h0;
      if (state == st_low_nibble) begin
         low_nib <= mii.data;
      end
      if (state == st_high_nibble) begin
         wr_addr_q <= byte_cnt[`ETH_BUF_AW-1:0];
         wr_data_q <= rx_byte;
         // destination address is the first six bytes
         if (byte_cnt < 6) begin
            dest <= dest_next;
         end
      end
      if ((state == st_low_nibble) && !mii.dv) begin
         frame_len_q <= byte_cnt;
      end
   end

   assign buf_wr = '{wr: wr_q, addr: wr_addr_q, data: wr_data_q};
   assign status = '{frame_received: frame_received_q, frame_len: frame_len_q};

endmodule

/* hw/eth_rx_buffer.sv */
`include "eth_macros.svh"

module eth_rx_buffer (
   input  logic                   RX_CLK,
   input  eth_buf_pkg::buf_wr_t   wr,
   input  logic [`ETH_BUF_AW-1:0] rd_addr,
   output logic [7:0]             rd_data
);
   import eth_buf_pkg::*;

   logic [7:0] mem [`ETH_BUF_DEPTH];

   // write side, one byte per strobe from the receiver
   always_ff @(posedge RX_CLK) begin
      if (wr.wr) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // host side, data one cycle after the address
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* hw/eth_rx_top.sv */
`include "eth_macros.svh"

module eth_rx_top (
   input  logic                    RX_CLK,
   input  logic                    rst,
   input  eth_mii_pkg::mii_rx_t    mii,
   input  logic                    receive,
   input  logic [`ETH_BUF_AW-1:0]  rd_addr,
   output logic [7:0]              rd_data,
   output eth_buf_pkg::rx_status_t status
);
   import eth_buf_pkg::*;

   // receiver to buffer
   buf_wr_t buf_wr;

   eth_rx i_rx (
      .RX_CLK  (RX_CLK),
      .rst     (rst),
      .mii     (mii),
      .receive (receive),
      .buf_wr  (buf_wr),
      .status  (status)
   );

   eth_rx_buffer i_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (buf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* verification/eth_rx_chk.sv */
module eth_rx_chk (
   input logic                    RX_CLK,
   input logic                    rst,
   input eth_mii_pkg::mii_rx_t    mii,
   input logic                    receive,
   input eth_buf_pkg::rx_status_t status
);
   timeunit 1ns;
   timeprecision 1ps;

   // failures seen so far, watched by the testbench
   int err_cnt = 0;

   a_reset_clear: assert property (@(posedge RX_CLK) rst |=> !status.frame_received)
      else begin
         $error("frame_received high in the cycle after reset");
         err_cnt++;
      end

   // last fcs nibble two cycles before the rise
   a_rise_latency: assert property (@(posedge RX_CLK) disable iff (rst)
      $rose(status.frame_received) |-> $past(mii.dv, 2) && !$past(mii.dv, 1))
      else begin
         $error("frame_received did not rise two cycles after the end of the frame");
         err_cnt++;
      end

   a_hold: assert property (@(posedge RX_CLK) disable iff (rst)
      status.frame_received && !receive |=> status.frame_received)
      else begin
         $error("frame_received dropped without receive");
         err_cnt++;
      end

   a_release: assert property (@(posedge RX_CLK) disable iff (rst)
      status.frame_received && receive |=> !status.frame_received)
      else begin
         $error("frame_received still high after receive");
         err_cnt++;
      end

endmodule

bind eth_rx_top eth_rx_chk i_chk (
   .RX_CLK  (RX_CLK),
   .rst     (rst),
   .mii     (mii),
   .receive (receive),
   .status  (status)
);

/* verification/eth_rx_tb.sv */
`include "eth_macros.svh"

module eth_rx_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import eth_mii_pkg::*;
   import eth_buf_pkg::*;

   localparam int HDR = 14;
   localparam int MAX_PAY = 60;
   localparam int GAP = 12;
   localparam int WAIT_CYC = 50;
   localparam int N_FRAMES = 17;
   localparam int MAX_FRAME_CYC = 2 * (8 + HDR + MAX_PAY + 4) + GAP + (HDR + MAX_PAY + 4) + 4;
   localparam logic [47:0] SRC_ADDR = 48'h0200_0000_0001;
   localparam logic [47:0] OTHER_ADDR = 48'h0200_5e10_2031;

   logic                   RX_CLK;
   logic                   rst;
   mii_rx_t                mii;
   logic                   receive;
   logic [`ETH_BUF_AW-1:0] rd_addr;
   logic [7:0]             rd_data;
   rx_status_t             status;

   logic [31:0] lcg = 32'd6;
   logic [7:0]  tx[$];
   logic [7:0]  expected [`ETH_BUF_DEPTH];
   int          exp_len = 0;
   logic        reading;
   logic        expect_drop;
   logic [7:0]  exp_rd;
   logic [7:0]  exp_rd_q;

   eth_rx_top i_dut (
      .RX_CLK  (RX_CLK),
      .rst     (rst),
      .mii     (mii),
      .receive (receive),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .status  (status)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #10 RX_CLK = ~RX_CLK;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic int unsigned next_rand();
      lcg = lcg * 32'd1103515245 + 32'd12345;
      return lcg >> 8;
   endfunction

   // bytewise crc-32 with final inversion, as sent on the wire
   function automatic logic [31:0] frame_crc(input int n);
      logic [31:0] c;
      c = 32'hffff_ffff;
      for (int i = 0; i < n; i++) begin
         c = c ^ {24'h0, tx[i]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   task automatic after_edge();
      @(posedge RX_CLK);
      #2;
   endtask

   task automatic drive_nibble(input logic dv, input logic er, input logic [3:0] d);
      after_edge();
      mii = '{dv: dv, er: er, data: d};
   endtask

   task automatic send_byte(input logic [7:0] b, input logic er);
      drive_nibble(1'b1, er, b[3:0]);
      drive_nibble(1'b1, 1'b0, b[7:4]);
   endtask

   task automatic send_frame(input logic [47:0] dest, input int pre_len, input int pay_len,
                             input logic bad_fcs, input int er_byte, input logic keep);
      logic [31:0] fcs;
      tx.delete();
      for (int i = 5; i >= 0; i--) tx.push_back(dest[8*i +: 8]);
      for (int i = 5; i >= 0; i--) tx.push_back(SRC_ADDR[8*i +: 8]);
      tx.push_back(8'h00);
      tx.push_back(8'(pay_len));
      for (int i = 0; i < pay_len; i++) tx.push_back(8'(next_rand()));
      fcs = frame_crc(tx.size());
      if (bad_fcs) begin
         fcs = fcs ^ (32'h1 << (next_rand() % 32));
      end
      // fcs goes out least significant byte first
      for (int i = 0; i < 4; i++) tx.push_back(fcs[8*i +: 8]);
      if (keep) begin
         foreach (tx[i]) expected[i] = tx[i];
         exp_len = tx.size();
      end
      for (int i = 0; i < pre_len; i++) send_byte(8'h55, 1'b0);
      send_byte(`ETH_SFD, 1'b0);
      foreach (tx[i]) send_byte(tx[i], i == er_byte);
      for (int i = 0; i < GAP; i++) drive_nibble(1'b0, 1'b0, 4'h0);
   endtask

   task automatic send_dropped(input logic [47:0] dest, input logic bad_fcs, input int er_byte);
      expect_drop = 1'b1;
      send_frame(dest, 7, 1 + int'(next_rand() % MAX_PAY), bad_fcs, er_byte, 1'b0);
      expect_drop = 1'b0;
   endtask

   task automatic wait_frame();
      int n;
      n = 0;
      while (!status.frame_received && n < WAIT_CYC) begin
         after_edge();
         n++;
      end
      if (!status.frame_received) begin
         stop_with_error("timed out waiting for frame_received to rise");
      end
   endtask

   // host model reads the whole frame then releases it
   task automatic host_read();
      wait_frame();
      for (int i = 0; i < exp_len; i++) begin
         after_edge();
         reading = 1'b1;
         rd_addr = `ETH_BUF_AW'(i);
         exp_rd  = expected[i];
      end
      after_edge();
      reading = 1'b0;
      receive = 1'b1;
      after_edge();
      receive = 1'b0;
   endtask

   always_ff @(posedge RX_CLK) begin
      exp_rd_q <= exp_rd;
   end

   a_len: assert property (@(posedge RX_CLK) disable iff (rst)
      $rose(status.frame_received) |-> int'(status.frame_len) == exp_len)
      else stop_with_error($sformatf("CHECK FAILED at %0t: frame_len %0d, expected %0d",
                                     $time, $sampled(status.frame_len), exp_len));

   a_data: assert property (@(posedge RX_CLK) disable iff (rst)
      reading |=> rd_data == exp_rd_q)
      else stop_with_error($sformatf("CHECK FAILED at %0t: rd_data %02h, expected %02h",
                                     $time, $sampled(rd_data), $sampled(exp_rd_q)));

   a_drop: assert property (@(posedge RX_CLK) disable iff (rst)
      expect_drop |-> !status.frame_received)
      else stop_with_error($sformatf("CHECK FAILED at %0t: frame_received for a bad frame",
                                     $time));

   always @(posedge RX_CLK) begin
      if (i_dut.i_chk.err_cnt != 0) begin
         stop_with_error("a protocol assertion on the DUT failed");
      end
   end

   initial begin
      repeat (N_FRAMES * MAX_FRAME_CYC * 4) @(posedge RX_CLK);
      stop_with_error("watchdog expired, the simulation appears to hang");
   end

   initial begin
      int pre_base;
      rst         = 1'b1;
      mii         = '0;
      receive     = 1'b0;
      rd_addr     = '0;
      reading     = 1'b0;
      expect_drop = 1'b0;
      exp_rd      = '0;
      repeat (10) @(posedge RX_CLK);
      #2;
      rst = 1'b0;
      repeat (4) after_edge();
      for (int i = 0; i < 3; i++) begin
         send_frame(`ETH_MAC_ADDR, 7, 1 + int'(next_rand() % MAX_PAY), 1'b0, -1, 1'b1);
         host_read();
      end
      send_frame('1, 7, 1 + int'(next_rand() % MAX_PAY), 1'b0, -1, 1'b1);
      host_read();
      send_dropped(OTHER_ADDR, 1'b0, -1);
      send_dropped(`ETH_MAC_ADDR, 1'b1, -1);
      // er on the first payload byte
      send_dropped(`ETH_MAC_ADDR, 1'b0, HDR);
      send_frame(`ETH_MAC_ADDR, 7, 1 + int'(next_rand() % MAX_PAY), 1'b0, -1, 1'b1);
      host_read();
      // second frame arrives while the first is held
      send_frame(`ETH_MAC_ADDR, 7, 1 + int'(next_rand() % MAX_PAY), 1'b0, -1, 1'b1);
      wait_frame();
      send_frame('1, 7, 1 + int'(next_rand() % MAX_PAY), 1'b0, -1, 1'b0);
      host_read();
      // every preamble length from 1 to 7, starting at a random one
      pre_base = int'(next_rand() % 7);
      for (int i = 0; i < 7; i++) begin
         send_frame(`ETH_MAC_ADDR, 1 + (pre_base + i) % 7, 1 + int'(next_rand() % MAX_PAY),
                    1'b0, -1, 1'b1);
         host_read();
      end
      repeat (4) after_edge();
      if (i_dut.i_chk.err_cnt == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         stop_with_error("protocol assertion failures were recorded");
      end
   end

endmodule

/* all.f */
+incdir+include
hw/eth_mii_pkg.sv
hw/eth_buf_pkg.sv
hw/eth_crc.sv
hw/eth_rx.sv
hw/eth_rx_buffer.sv
hw/eth_rx_top.sv
verification/eth_rx_chk.sv
verification/eth_rx_tb.sv

/* Bender.yml */
package:
  name: eth_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/eth_mii_pkg.sv
      - hw/eth_buf_pkg.sv
      - hw/eth_crc.sv
      - hw/eth_rx.sv
      - hw/eth_rx_buffer.sv
      - hw/eth_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/eth_rx_chk.sv
      - verification/eth_rx_tb.sv
